// File: common/x86_decode_pkg.sv
package x86_decode_pkg;

    // Default queue depth and consumer buffer size.
    localparam int DEF_QUEUE_DEPTH = 4;
    localparam int DEF_OUT_CREDITS = 3;

    // 16-byte fetch window, byte 0 in bits 127:120.
    typedef struct packed {
        logic [127:0] bytes;
        logic [31:0]  eip;
    } fetch_window_t;

    // Summary of the leading prefix bytes.
    // rep_kind is 0 for REP (F3) and 1 for REPNE (F2).
    // seg_override is one-hot in ES CS SS DS FS GS order, ES in bit 0.
    typedef struct packed {
        logic       is_rep;
        logic       rep_kind;
        logic [5:0] seg_override;
        logic       is_seg_override;
        logic       is_opsize_override;
        logic [1:0] num_prefixes;
        logic       dup_prefix;
    } prefix_info_t;

    typedef enum logic [3:0] {
        OP_NOP     = 4'd0,
        OP_ADD_RM  = 4'd1,
        OP_ADD_IMM = 4'd2,
        OP_MOV_RM  = 4'd3,
        OP_MOV_IMM = 4'd4,
        OP_JMP_REL = 4'd5,
        OP_MOVS    = 4'd6,
        OP_RET     = 4'd7,
        OP_ILLEGAL = 4'd8
    } op_class_e;

    // Queue payload.
    // Sizes are in bytes. JMP offsets travel in imm, sign-extended.
    typedef struct packed {
        logic [31:0]  eip;
        op_class_e    op_class;
        prefix_info_t prefix;
        logic         has_modrm;
        logic [7:0]   modrm;
        logic [31:0]  disp;
        logic [2:0]   disp_size;
        logic [31:0]  imm;
        logic [2:0]   imm_size;
        logic [3:0]   length;
        logic         illegal;
    } decoded_uop_t;

endpackage

// File: src/prefix_lut.sv
`timescale 1ns/10ps

module prefix_lut (
    input  logic [7:0] prefix,
    output logic       is_rep,
    output logic       rep_kind,
    output logic [5:0] seg_override,
    output logic       is_opsize_override
);

    always_comb begin
        is_rep             = 1'b0;
        rep_kind           = 1'b0;
        seg_override       = 6'b000000;
        is_opsize_override = 1'b0;
        case (prefix)
            8'hF3: is_rep = 1'b1;
            8'hF2: begin
                is_rep   = 1'b1;
                rep_kind = 1'b1;
            end
            // Segment overrides, one bit each.
            8'h26: seg_override = 6'b000001;
            8'h2E: seg_override = 6'b000010;
            8'h36: seg_override = 6'b000100;
            8'h3E: seg_override = 6'b001000;
            8'h64: seg_override = 6'b010000;
            8'h65: seg_override = 6'b100000;
            8'h66: is_opsize_override = 1'b1;
            default: begin
                is_rep = 1'b0;
            end
        endcase
    end

endmodule

// File: src/prefix_decode.sv
`timescale 1ns/10ps

module prefix_decode (
    input  logic [127:0]                 window_bytes,
    output x86_decode_pkg::prefix_info_t info
);

    logic [2:0] is_rep;
    logic [2:0] rep_kind;
    logic [2:0] is_opsize;
    logic [2:0] has_seg;
    logic [2:0] is_pfx;
    logic [5:0] seg [3];
    logic [2:0] counts;
    logic [2:0] rep_hit;
    logic [2:0] seg_hit;
    logic [2:0] opsize_hit;

    for (genvar i = 0; i < 3; i++) begin : g_lut
        prefix_lut lut_i (
            .prefix             (window_bytes[127 - 8 * i -: 8]),
            .is_rep             (is_rep[i]),
            .rep_kind           (rep_kind[i]),
            .seg_override       (seg[i]),
            .is_opsize_override (is_opsize[i])
        );

        assign has_seg[i] = |seg[i];
        assign is_pfx[i]  = is_rep[i] | has_seg[i] | is_opsize[i];
    end

    // Byte n counts only behind an unbroken run of prefixes.
    assign counts[0] = is_pfx[0];
    assign counts[1] = counts[0] & is_pfx[1];
    assign counts[2] = counts[1] & is_pfx[2];

    assign rep_hit    = is_rep & counts;
    assign seg_hit    = has_seg & counts;
    assign opsize_hit = is_opsize & counts;

    function automatic logic two_or_more(input logic [2:0] v);
        return (v[0] & v[1]) | (v[0] & v[2]) | (v[1] & v[2]);
    endfunction

    always_comb begin
        info                    = '0;
        info.is_rep             = |rep_hit;
        info.rep_kind           = |(rep_kind & counts);
        info.is_seg_override    = |seg_hit;
        info.is_opsize_override = |opsize_hit;
        for (int i = 0; i < 3; i++) begin
            if (counts[i]) begin
                info.seg_override = info.seg_override | seg[i];
            end
        end
        // Counts is a thermometer code, so the sum is the run length.
        info.num_prefixes = {1'b0, counts[0]} + {1'b0, counts[1]} + {1'b0, counts[2]};
        // Two different segment bytes are a repeat of the same kind.
        info.dup_prefix = two_or_more(rep_hit) | two_or_more(seg_hit)
                        | two_or_more(opsize_hit);
    end

endmodule

// File: opcode_decode/opcode_decode.sv
`timescale 1ns/10ps

module opcode_decode (
    input  x86_decode_pkg::fetch_window_t window,
    input  x86_decode_pkg::prefix_info_t  info,
    output x86_decode_pkg::decoded_uop_t  uop
);
    import x86_decode_pkg::*;

    logic [4:0] op_pos;
    logic [4:0] modrm_pos;
    logic [4:0] sib_pos;
    logic [4:0] disp_pos;
    logic [4:0] imm_pos;
    logic [4:0] end_pos;
    logic [7:0] opcode;
    logic [7:0] modrm;
    logic [7:0] sib;
    op_class_e  op_class;
    logic       known;
    logic       has_modrm;
    logic       has_sib;
    logic       imm_signed;
    logic [2:0] disp_size;
    logic [2:0] imm_size;
    logic [31:0] disp_raw;
    logic [31:0] imm_raw;
    logic [31:0] disp_val;
    logic [31:0] imm_val;
    logic       illegal;

    function automatic logic [7:0] byte_at(input logic [127:0] bytes, input logic [4:0] pos);
        logic [7:0] b;
        b = 8'h00;
        if (pos < 5'd16) begin
            b = bytes[127 - 8 * pos -: 8];
        end
        return b;
    endfunction

    // Little-endian field starting at pos.
    function automatic logic [31:0] le32_at(input logic [127:0] bytes, input logic [4:0] pos);
        logic [31:0] v;
        for (int k = 0; k < 4; k++) begin
            v[8 * k +: 8] = byte_at(bytes, pos + 5'(k));
        end
        return v;
    endfunction

    assign op_pos    = {3'b000, info.num_prefixes};
    assign modrm_pos = op_pos + 5'd1;
    assign sib_pos   = op_pos + 5'd2;
    assign opcode    = byte_at(window.bytes, op_pos);
    assign modrm     = byte_at(window.bytes, modrm_pos);
    assign sib       = byte_at(window.bytes, sib_pos);

    always_comb begin
        op_class   = OP_ILLEGAL;
        known      = 1'b0;
        has_modrm  = 1'b0;
        imm_size   = 3'd0;
        imm_signed = 1'b0;
        case (opcode) inside
            8'h90: begin
                op_class = OP_NOP;
                known    = 1'b1;
            end
            8'h01, 8'h03: begin
                op_class  = OP_ADD_RM;
                known     = 1'b1;
                has_modrm = 1'b1;
            end
            8'h05: begin
                op_class = OP_ADD_IMM;
                known    = 1'b1;
                imm_size = info.is_opsize_override ? 3'd2 : 3'd4;
            end
            8'h89, 8'h8B: begin
                op_class  = OP_MOV_RM;
                known     = 1'b1;
                has_modrm = 1'b1;
            end
            [8'hB8:8'hBF]: begin
                op_class = OP_MOV_IMM;
                known    = 1'b1;
                imm_size = info.is_opsize_override ? 3'd2 : 3'd4;
            end
            8'hEB: begin
                op_class   = OP_JMP_REL;
                known      = 1'b1;
                imm_size   = 3'd1;
                imm_signed = 1'b1;
            end
            8'hE9: begin
                op_class   = OP_JMP_REL;
                known      = 1'b1;
                imm_size   = info.is_opsize_override ? 3'd2 : 3'd4;
                imm_signed = 1'b1;
            end
            8'hA4, 8'hA5: begin
                op_class = OP_MOVS;
                known    = 1'b1;
            end
            8'hC3: begin
                op_class = OP_RET;
                known    = 1'b1;
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    // SIB follows any memory form with rm 100.
    assign has_sib = has_modrm && (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'b100);

    always_comb begin
        disp_size = 3'd0;
        if (has_modrm) begin
            case (modrm[7:6])
                2'b01: disp_size = 3'd1;
                2'b10: disp_size = 3'd4;
                2'b00: begin
                    if (modrm[2:0] == 3'b101 || (has_sib && sib[2:0] == 3'b101)) begin
                        disp_size = 3'd4;
                    end
                end
                default: disp_size = 3'd0;
            endcase
        end
    end

    assign disp_pos = modrm_pos + 5'd1 + {4'b0000, has_sib};
    assign imm_pos  = modrm_pos + {4'b0000, has_modrm} + {4'b0000, has_sib}
                    + {2'b00, disp_size};
    assign end_pos  = imm_pos + {2'b00, imm_size};
    assign disp_raw = le32_at(window.bytes, disp_pos);
    assign imm_raw  = le32_at(window.bytes, imm_pos);

    always_comb begin
        case (disp_size)
            3'd1:    disp_val = {{24{disp_raw[7]}}, disp_raw[7:0]};
            3'd4:    disp_val = disp_raw;
            default: disp_val = 32'h0;
        endcase
        case (imm_size)
            3'd1:    imm_val = {{24{imm_signed & imm_raw[7]}}, imm_raw[7:0]};
            3'd2:    imm_val = {{16{imm_signed & imm_raw[15]}}, imm_raw[15:0]};
            3'd4:    imm_val = imm_raw;
            default: imm_val = 32'h0;
        endcase
    end

    assign illegal = !known || info.dup_prefix;

    always_comb begin
        uop           = '0;
        uop.eip       = window.eip;
        uop.prefix    = info;
        uop.illegal   = illegal;
        uop.op_class  = illegal ? OP_ILLEGAL : op_class;
        // Illegal forms consume the prefixes and the opcode byte only.
        uop.length    = illegal ? modrm_pos[3:0] : end_pos[3:0];
        if (!illegal) begin
            uop.has_modrm = has_modrm;
            uop.modrm     = has_modrm ? modrm : 8'h00;
            uop.disp      = disp_val;
            uop.disp_size = disp_size;
            uop.imm       = imm_val;
            uop.imm_size  = imm_size;
        end
    end

endmodule

// File: src/uop_credit_queue.sv
`timescale 1ns/10ps

module uop_credit_queue #(
    parameter int  DEPTH     = 4,
    parameter int  CREDITS   = 3,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     credit_return,
    output logic     out_valid,
    output payload_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(CREDITS + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic [CRD_W-1:0] credits;
    logic             send;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Head leaves as soon as the consumer has room for it.
    assign send       = (count != '0) && (credits != '0);
    assign count_next = count + CNT_W'(push) - CNT_W'(send);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            full      <= 1'b0;
            credits   <= CRD_W'(CREDITS);
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (send) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count     <= count_next;
            full      <= (count_next == CNT_W'(DEPTH));
            credits   <= credits - CRD_W'(send) + CRD_W'(credit_return);
            out_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
        if (send) begin
            out_data <= mem[rd_ptr];
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    );

    // A return with no send in flight must not lift the count past CREDITS.
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credit_return |-> (send || credits < CRD_W'(CREDITS))
    );

    a_send_credit: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> $past(credits) != '0
    );

endmodule

// File: src/decode_stage_top.sv
`timescale 1ns/10ps

module decode_stage_top #(
    parameter int QUEUE_DEPTH = x86_decode_pkg::DEF_QUEUE_DEPTH,
    parameter int OUT_CREDITS = x86_decode_pkg::DEF_OUT_CREDITS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  x86_decode_pkg::fetch_window_t window,
    output logic                          in_ready,
    output logic [3:0]                    consumed_len,
    output logic                          uop_valid,
    output x86_decode_pkg::decoded_uop_t  uop,
    input  logic                          credit_return
);
    import x86_decode_pkg::*;

    prefix_info_t prefix_info;
    decoded_uop_t decoded;
    logic         queue_full;
    logic         push;

    prefix_decode prefix_decode_i (
        .window_bytes (window.bytes),
        .info         (prefix_info)
    );

    opcode_decode opcode_decode_i (
        .window (window),
        .info   (prefix_info),
        .uop    (decoded)
    );

    // Fetch advances by the decoded length in the accepting cycle.
    assign consumed_len = decoded.length;
    assign in_ready     = !queue_full;
    assign push         = in_valid && in_ready;

    uop_credit_queue #(
        .DEPTH     (QUEUE_DEPTH),
        .CREDITS   (OUT_CREDITS),
        .payload_t (decoded_uop_t)
    ) queue_i (
        .clk           (clk),
        .rst           (rst),
        .push          (push),
        .push_data     (decoded),
        .full          (queue_full),
        .credit_return (credit_return),
        .out_valid     (uop_valid),
        .out_data      (uop)
    );

    // Fetch holds its window while stalled.
    a_window_hold: assert property (
        @(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=> (in_valid && $stable(window))
    );

endmodule

// File: testbench/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Each row gives the first 8 window bytes, the length, the class and the illegal flag,
// then segment one-hot, REP, operand size, prefix count, displacement and immediate.
// Window bytes past the first 8 are filled with CC.
task automatic build_vector_table();
    add_vector(64'h90CC_CCCC_CCCC_CCCC, 1, OP_NOP, 0, 6'b000000, 0, 0, 0, 32'h0, 32'h0);
    add_vector(64'h01C8_CCCC_CCCC_CCCC, 2, OP_ADD_RM, 0, 6'b000000, 0, 0, 0, 32'h0, 32'h0);
    add_vector(64'h8B45_F8CC_CCCC_CCCC, 3, OP_MOV_RM, 0, 6'b000000, 0, 0, 0, 32'hFFFF_FFF8, 0);
    add_vector(64'h8986_7856_3412_CCCC, 6, OP_MOV_RM, 0, 6'b000000, 0, 0, 0, 32'h1234_5678, 0);
    add_vector(64'h0305_4433_2211_CCCC, 6, OP_ADD_RM, 0, 6'b000000, 0, 0, 0, 32'h1122_3344, 0);
    add_vector(64'h8B04_25DD_CCBB_AACC, 7, OP_MOV_RM, 0, 6'b000000, 0, 0, 0, 32'hAABB_CCDD, 0);
    add_vector(64'h8B04_88CC_CCCC_CCCC, 3, OP_MOV_RM, 0, 6'b000000, 0, 0, 0, 32'h0, 32'h0);
    add_vector(64'h0578_5634_12CC_CCCC, 5, OP_ADD_IMM, 0, 6'b000000, 0, 0, 0, 0, 32'h1234_5678);
    add_vector(64'h6605_3412_CCCC_CCCC, 4, OP_ADD_IMM, 0, 6'b000000, 0, 1, 1, 0, 32'h0000_1234);
    add_vector(64'hBBEF_BEAD_DECC_CCCC, 5, OP_MOV_IMM, 0, 6'b000000, 0, 0, 0, 0, 32'hDEAD_BEEF);
    add_vector(64'h66B9_CDAB_CCCC_CCCC, 4, OP_MOV_IMM, 0, 6'b000000, 0, 1, 1, 0, 32'h0000_ABCD);
    add_vector(64'hEBFE_CCCC_CCCC_CCCC, 2, OP_JMP_REL, 0, 6'b000000, 0, 0, 0, 0, 32'hFFFF_FFFE);
    add_vector(64'hE900_0100_00CC_CCCC, 5, OP_JMP_REL, 0, 6'b000000, 0, 0, 0, 0, 32'h0000_0100);
    add_vector(64'h66E9_0080_CCCC_CCCC, 4, OP_JMP_REL, 0, 6'b000000, 0, 1, 1, 0, 32'hFFFF_8000);
    // Prefix combinations.
    add_vector(64'hF3A4_CCCC_CCCC_CCCC, 2, OP_MOVS, 0, 6'b000000, 1, 0, 1, 32'h0, 32'h0);
    add_vector(64'hF32E_A5CC_CCCC_CCCC, 3, OP_MOVS, 0, 6'b000010, 1, 0, 2, 32'h0, 32'h0);
    add_vector(64'h6466_8B00_CCCC_CCCC, 4, OP_MOV_RM, 0, 6'b010000, 0, 1, 2, 32'h0, 32'h0);
    add_vector(64'h66F3_2EA5_CCCC_CCCC, 4, OP_MOVS, 0, 6'b000010, 1, 1, 3, 32'h0, 32'h0);
    add_vector(64'hF364_66C3_CCCC_CCCC, 4, OP_RET, 0, 6'b010000, 1, 1, 3, 32'h0, 32'h0);
    // Unknown opcodes and repeated segment prefixes.
    add_vector(64'h2EFF_CCCC_CCCC_CCCC, 2, OP_ILLEGAL, 1, 6'b000010, 0, 0, 1, 32'h0, 32'h0);
    add_vector(64'h2E2E_90CC_CCCC_CCCC, 3, OP_ILLEGAL, 1, 6'b000010, 0, 0, 2, 32'h0, 32'h0);
    add_vector(64'h3E65_90CC_CCCC_CCCC, 3, OP_ILLEGAL, 1, 6'b101000, 0, 0, 2, 32'h0, 32'h0);
    add_vector(64'h0F0B_CCCC_CCCC_CCCC, 1, OP_ILLEGAL, 1, 6'b000000, 0, 0, 0, 32'h0, 32'h0);
endtask

`endif

// File: testbench/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;
    import x86_decode_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 3;
    localparam int WAIT_LIMIT  = 100;

    // Window and its expected decode.
    typedef struct packed {
        logic [127:0] bytes;
        logic [31:0]  eip;
        logic [3:0]   len;
        op_class_e    op_class;
        logic         illegal;
        logic [5:0]   seg;
        logic         is_rep;
        logic         opsize;
        logic [1:0]   npfx;
        logic [31:0]  disp;
        logic [31:0]  imm;
    } vector_t;

    logic          clk = 1'b0;
    logic          rst;
    logic          in_valid;
    fetch_window_t window;
    logic          in_ready;
    logic [3:0]    consumed_len;
    logic          uop_valid;
    decoded_uop_t  uop;
    logic          credit_return;

    vector_t     table_q[$];
    vector_t     expected_q[$];
    int          due_q[$];
    integer      seed;
    int          cycle = 0;
    int          in_flight = 0;
    int          received = 0;
    int          accepted = 0;
    int          errors = 0;
    int          order_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          hold_credits = 1'b0;
    bit          aborted = 1'b0;
    logic [31:0] next_eip = 32'h0040_1000;

    decode_stage_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .window        (window),
        .in_ready      (in_ready),
        .consumed_len  (consumed_len),
        .uop_valid     (uop_valid),
        .uop           (uop),
        .credit_return (credit_return)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic add_vector(input logic [63:0] head, input int len, input op_class_e cls,
                              input bit illegal, input logic [5:0] seg, input bit is_rep,
                              input bit opsize, input int npfx, input logic [31:0] disp,
                              input logic [31:0] imm);
        vector_t v;
        v.bytes    = {head, 64'hCCCC_CCCC_CCCC_CCCC};
        v.eip      = 32'h0;
        v.len      = 4'(len);
        v.op_class = cls;
        v.illegal  = illegal;
        v.seg      = seg;
        v.is_rep   = is_rep;
        v.opsize   = opsize;
        v.npfx     = 2'(npfx);
        v.disp     = disp;
        v.imm      = imm;
        table_q.push_back(v);
    endtask

    `include "decode_vectors.svh"

    function automatic void check_field(input string name, input logic [31:0] got,
                                        input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endfunction

    // Consumer returns each credit 0 to 3 cycles after its uop.
    always @(posedge clk) begin
        #2;
        credit_return = 1'b0;
        if (!rst && !hold_credits && due_q.size() > 0) begin
            if (due_q[0] <= cycle) begin
                credit_return = 1'b1;
                void'(due_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        vector_t want;
        if (!rst && uop_valid) begin
            if (in_flight >= OUT_CREDITS) begin
                $display("uop delivered while the consumer had no credit left");
                errors++;
            end
            in_flight++;
            received++;
            due_q.push_back(cycle + int'($unsigned($random(seed)) % 4));
            if (expected_q.size() == 0) begin
                $display("uop at eip %h arrived with nothing expected", uop.eip);
                errors++;
            end else begin
                want = expected_q.pop_front();
                if (uop.eip !== want.eip) begin
                    $display("[FAIL] uop.eip: got %h, expected %h", uop.eip, want.eip);
                    order_errors++;
                end
                check_field("uop.op_class", uop.op_class, want.op_class);
                check_field("uop.length", uop.length, want.len);
                check_field("uop.illegal", uop.illegal, want.illegal);
                check_field("uop.prefix.seg_override", uop.prefix.seg_override, want.seg);
                check_field("uop.prefix.is_seg_override", uop.prefix.is_seg_override,
                            |want.seg);
                check_field("uop.prefix.is_rep", uop.prefix.is_rep, want.is_rep);
                check_field("uop.prefix.is_opsize_override",
                            uop.prefix.is_opsize_override, want.opsize);
                check_field("uop.prefix.num_prefixes", uop.prefix.num_prefixes, want.npfx);
                check_field("uop.disp", uop.disp, want.disp);
                check_field("uop.imm", uop.imm, want.imm);
            end
        end
        if (!rst && credit_return) begin
            in_flight--;
        end
    end

    task automatic apply(input vector_t v);
        vector_t want;
        int      waited;
        if (aborted) begin
            return;
        end
        want         = v;
        want.eip     = next_eip;
        in_valid     = 1'b1;
        window.bytes = v.bytes;
        window.eip   = next_eip;
        waited       = 0;
        @(negedge clk);
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("timeout waiting for the window at eip %h to be accepted", next_eip);
            errors++;
            aborted = 1'b1;
        end else begin
            check_field("consumed_len", consumed_len, v.len);
            @(posedge clk);
            expected_q.push_back(want);
            accepted++;
            next_eip = next_eip + v.len;
            #2;
        end
        in_valid = 1'b0;
    endtask

    // Waits until every accepted uop arrived and all credits came back.
    task automatic drain();
        int waited;
        waited = 0;
        while ((expected_q.size() != 0 || in_flight != 0) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0 || in_flight != 0) begin
            $display("timeout waiting for uop_valid, %0d uops never arrived", expected_q.size());
            errors++;
            aborted = 1'b1;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic report(input string name, input bit ok);
        tests_run++;
        if (ok) begin
            $display("test %0d, %s: passed", tests_run, name);
        end else begin
            $display("test %0d, %s: failed", tests_run, name);
            tests_failed++;
        end
    endtask

    task automatic run_range(input int first, input int last, input string name);
        int start_errors;
        start_errors = errors;
        for (int i = first; i <= last; i++) begin
            apply(table_q[i]);
        end
        drain();
        report(name, errors == start_errors);
    endtask

    task automatic back_pressure();
        int start_errors;
        int start_received;
        start_errors   = errors;
        start_received = received;
        hold_credits   = 1'b1;
        for (int i = 0; i < QUEUE_DEPTH + OUT_CREDITS; i++) begin
            apply(table_q[i]);
        end
        // One more window stalls against the full queue.
        in_valid     = 1'b1;
        window.bytes = table_q[QUEUE_DEPTH + OUT_CREDITS].bytes;
        window.eip   = next_eip;
        repeat (6) @(negedge clk);
        if (in_ready !== 1'b0) begin
            $display("[FAIL] in_ready: got %h, expected %h", in_ready, 1'b0);
            errors++;
        end
        if (received - start_received != OUT_CREDITS) begin
            $display("%0d uops delivered while credits were held, expected %0d",
                     received - start_received, OUT_CREDITS);
            errors++;
        end
        hold_credits = 1'b0;
        @(posedge clk);
        #2;
        apply(table_q[QUEUE_DEPTH + OUT_CREDITS]);
        drain();
        report("back-pressure", errors == start_errors);
    endtask

    initial begin
        int start_errors;
        seed          = 32'h57e90fa5;
        rst           = 1'b1;
        in_valid      = 1'b0;
        window        = '0;
        credit_return = 1'b0;
        build_vector_table();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        start_errors = errors;
        check_field("in_ready", in_ready, 1'b1);
        check_field("uop_valid", uop_valid, 1'b0);
        report("reset state", errors == start_errors);
        run_range(14, 18, "prefix summary");
        run_range(0, 13, "instruction length");
        run_range(19, 22, "illegal opcodes and repeated prefixes");
        back_pressure();
        report("order and address",
               order_errors == 0 && received == accepted && expected_q.size() == 0);
        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors + order_errors);
        if (tests_failed == 0 && errors == 0 && order_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+testbench
common/x86_decode_pkg.sv
src/prefix_lut.sv
src/prefix_decode.sv
opcode_decode/opcode_decode.sv
src/uop_credit_queue.sv
src/decode_stage_top.sv
testbench/decode_stage_tb.sv

// File: Bender.yml
package:
  name: x86_decode_stage

sources:
  - files:
      - common/x86_decode_pkg.sv
      - src/prefix_lut.sv
      - src/prefix_decode.sv
      - opcode_decode/opcode_decode.sv
      - src/uop_credit_queue.sv
      - src/decode_stage_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/decode_stage_tb.sv
